// File: Bender.yml
package:
  name: alu_array

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/alu_pkg.sv
      - rtl/alu_apb_regs.sv
      - rtl/alu_lane.sv
      - rtl/alu_collect.sv
      - rtl/alu_array_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/alu_array_tb.sv

// File: bench/alu_array_tb.sv
`include "alu_defines.svh"

module alu_array_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int NL         = `ALU_NUM_LANES;
  localparam int R_SINGLE   = 3;
  localparam int R_BRANCH   = 4;
  localparam int R_MULTI    = 8;
  localparam int MAX_POLL   = 8;
  localparam int LAUNCHES   = 11 * R_SINGLE + 6 * R_BRANCH + R_MULTI + 4;
  localparam int XFER_PER_LAUNCH = NL * 5 + 1 + MAX_POLL + 2 * NL + 2;
  localparam int PLANNED_XFERS   = LAUNCHES * XFER_PER_LAUNCH + 40;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`ALU_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  logic [31:0]         lfsr_q;
  int                  res_errs;
  int                  done_errs;
  int                  bus_errs;
  alu_pkg::alu_op_e    prog_op [NL];
  logic [31:0]         prog_src [NL][4];
  logic [31:0]         exp_res1 [NL];
  logic [31:0]         exp_res2 [NL];
  alu_pkg::lane_mask_t model_done;

  alu_pkg::alu_op_e single_ops [11] = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_SLT,
    alu_pkg::OP_SLTU, alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR, alu_pkg::OP_SLL,
    alu_pkg::OP_SRL, alu_pkg::OP_SRA, alu_pkg::OP_LUI};
  alu_pkg::alu_op_e branch_ops [6] = '{alu_pkg::OP_BNE, alu_pkg::OP_BEQ, alu_pkg::OP_BGE,
    alu_pkg::OP_BGEU, alu_pkg::OP_BLT, alu_pkg::OP_BLTU};
  // Zero op, two op bits, double_cal on xor, beq without double_cal.
  logic [31:0] bad_ctrl [4] = '{32'h0, 32'(alu_pkg::OP_ADD) | 32'(alu_pkg::OP_SUB),
    32'h8000_0000 | 32'(alu_pkg::OP_XOR), 32'(alu_pkg::OP_BEQ)};

  alu_array_top u_alu_array_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (b ? 32'hD000_0001 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [2:0] sel;
    sel = 3'(rand_bits(3));
    case (sel)
      3'd0: return 32'h8000_0000;
      3'd1: return 32'hFFFF_FFFF;
      3'd2: return rand_bits(5);                      // Small, a shift amount.
      default: return rand_bits(32);
    endcase
  endfunction

  function automatic logic [31:0] model_res1(input alu_pkg::alu_op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    case (op)
      alu_pkg::OP_SUB:  return a - b;
      alu_pkg::OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
      alu_pkg::OP_SLTU: return {31'b0, a < b};
      alu_pkg::OP_AND:  return a & b;
      alu_pkg::OP_OR:   return a | b;
      alu_pkg::OP_XOR:  return a ^ b;
      alu_pkg::OP_SLL:  return a << b[4:0];
      alu_pkg::OP_SRL:  return a >> b[4:0];
      alu_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
      alu_pkg::OP_LUI:  return b;
      default:          return a + b;                 // Add and branch target.
    endcase
  endfunction

  function automatic logic [31:0] model_res2(input alu_pkg::alu_op_e op,
                                             input logic [31:0] c, input logic [31:0] d);
    case (op)
      alu_pkg::OP_BEQ:  return {31'b0, c == d};
      alu_pkg::OP_BNE:  return {31'b0, c != d};
      alu_pkg::OP_BLT:  return {31'b0, $signed(c) < $signed(d)};
      alu_pkg::OP_BGE:  return {31'b0, $signed(c) >= $signed(d)};
      alu_pkg::OP_BLTU: return {31'b0, c < d};
      alu_pkg::OP_BGEU: return {31'b0, c >= d};
      default:          return 32'd1;
    endcase
  endfunction

  function automatic logic [`ALU_ADDR_W-1:0] lane_addr(input int lane,
                                                       input logic [`ALU_ADDR_W-1:0] ofs);
    return `ALU_ADDR_W'(lane * `ALU_LANE_STRIDE) + ofs;
  endfunction

  // No wait states, so every access phase must see pready.
  task automatic check_ready(input logic got);
    if (got !== 1'b1) begin
      bus_errs++;
      $display("pready was not high in an access phase");
    end
  endtask

  task automatic apb_write(input logic [`ALU_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    @(posedge clk);
    #DRIVE_DLY penable = 1'b1;
    @(negedge clk);
    err = pslverr;                                    // Mid access phase.
    check_ready(pready);
    @(posedge clk);
    #DRIVE_DLY psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`ALU_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    @(posedge clk);
    #DRIVE_DLY penable = 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_ready(pready);
    @(posedge clk);
    #DRIVE_DLY psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_result(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    if (got !== exp) begin
      res_errs++;
      $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
    end
  endtask

  task automatic check_done(input alu_pkg::lane_mask_t exp, input alu_pkg::lane_mask_t got);
    if (got !== exp) begin
      done_errs++;
      $display("Fail done: expected 0x%h, got 0x%h", exp, got);
    end
  endtask

  task automatic check_err(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      bus_errs++;
      if (exp)
        $display("No pslverr on %s", what);
      else
        $display("Unexpected pslverr on %s", what);
    end
  endtask

  task automatic write_ok(input logic [`ALU_ADDR_W-1:0] addr, input logic [31:0] data,
                          input string what);
    logic err;
    apb_write(addr, data, err);
    check_err(what, 1'b0, err);
  endtask

  task automatic read_ok(input logic [`ALU_ADDR_W-1:0] addr, output logic [31:0] data,
                         input string what);
    logic err;
    apb_read(addr, data, err);
    check_err(what, 1'b0, err);
  endtask

  task automatic expect_write_err(input logic [`ALU_ADDR_W-1:0] addr,
                                  input logic [31:0] data, input string what);
    logic err;
    apb_write(addr, data, err);
    check_err(what, 1'b1, err);
  endtask

  task automatic program_lane(input int lane, input alu_pkg::alu_op_e op,
                              input logic [31:0] s1, input logic [31:0] s2,
                              input logic [31:0] s3, input logic [31:0] s4);
    logic [31:0] ctrl;
    ctrl = 32'(op);
    ctrl[`ALU_CTRL_DCAL] = (op inside {alu_pkg::OP_BNE, alu_pkg::OP_BEQ, alu_pkg::OP_BGE,
                                       alu_pkg::OP_BGEU, alu_pkg::OP_BLT, alu_pkg::OP_BLTU});
    write_ok(lane_addr(lane, `ALU_REG_CTRL), ctrl, "CTRL write");
    prog_op[lane]     = op;
    prog_src[lane][0] = s1;
    prog_src[lane][1] = s2;
    prog_src[lane][2] = s3;
    prog_src[lane][3] = s4;
    for (int k = 0; k < 4; k++)
      write_ok(lane_addr(lane, `ALU_REG_SRC1 + 4 * k), prog_src[lane][k], "SRC write");
  endtask

  task automatic issue_lanes(input alu_pkg::lane_mask_t mask);
    write_ok(`ALU_REG_GO, 32'(mask), "GO write");
    for (int i = 0; i < NL; i++) begin
      if (mask[i]) begin
        exp_res1[i] = model_res1(prog_op[i], prog_src[i][0], prog_src[i][1]);
        exp_res2[i] = model_res2(prog_op[i], prog_src[i][2], prog_src[i][3]);
      end
    end
  endtask

  // Poll DONE until every launched lane reports.
  task automatic wait_done(input alu_pkg::lane_mask_t mask);
    logic [31:0] rd;
    int          tries;
    read_ok(`ALU_REG_DONE, rd, "DONE read");
    tries = 1;
    while (((rd[NL-1:0] & mask) != mask) && (tries < MAX_POLL)) begin
      read_ok(`ALU_REG_DONE, rd, "DONE read");
      tries++;
    end
    if ((rd[NL-1:0] & mask) != mask) begin
      done_errs++;
      $display("Lanes 0x%h never reported done", mask);
    end
    model_done = model_done | mask;
    check_done(model_done, rd[NL-1:0]);
  endtask

  task automatic check_lane_results();
    logic [31:0] rd;
    for (int i = 0; i < NL; i++) begin
      read_ok(lane_addr(i, `ALU_REG_RES1), rd, "RES1 read");
      check_result($sformatf("lane%0d result1", i), exp_res1[i], rd);
      read_ok(lane_addr(i, `ALU_REG_RES2), rd, "RES2 read");
      check_result($sformatf("lane%0d result2", i), exp_res2[i], rd);
    end
  endtask

  initial begin
    logic [31:0]         rd;
    logic                err;
    logic [31:0]         a;
    logic [31:0]         c;
    logic [31:0]         d;
    alu_pkg::lane_mask_t mask;
    alu_pkg::lane_mask_t prev;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr_q     = 32'h6a3a507c;
    res_errs   = 0;
    done_errs  = 0;
    bus_errs   = 0;
    model_done = '0;
    for (int i = 0; i < NL; i++) begin
      exp_res1[i] = '0;
      exp_res2[i] = '0;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;

    // Reset state. Unprogrammed lanes hold an illegal control, so none is issued.
    read_ok(`ALU_REG_DONE, rd, "DONE read");
    check_done('0, rd[NL-1:0]);
    check_lane_results();

    foreach (single_ops[k]) begin
      for (int r = 0; r < R_SINGLE; r++) begin
        for (int i = 0; i < NL; i++)
          program_lane(i, single_ops[k], pick_operand(), pick_operand(), pick_operand(),
                       pick_operand());
        issue_lanes('1);
        wait_done('1);
        check_lane_results();
      end
    end

    foreach (branch_ops[k]) begin
      for (int r = 0; r < R_BRANCH; r++) begin
        for (int i = 0; i < NL; i++) begin
          c = pick_operand();
          case ((i + r) % 3)
            0: d = c;
            1: begin
              c = 32'h8000_0000 | rand_bits(31);      // Signed and unsigned disagree.
              d = rand_bits(31);
              if (lfsr_bit()) begin
                a = c;
                c = d;
                d = a;
              end
            end
            default: d = pick_operand();
          endcase
          program_lane(i, branch_ops[k], pick_operand(), pick_operand(), c, d);
        end
        issue_lanes('1);
        wait_done('1);
        check_lane_results();
      end
    end

    // Multi-lane launch with a random mask.
    for (int r = 0; r < R_MULTI; r++) begin
      for (int i = 0; i < NL; i++) begin
        if (lfsr_bit())
          program_lane(i, branch_ops[rand_bits(5) % 6], pick_operand(), pick_operand(),
                       pick_operand(), pick_operand());
        else
          program_lane(i, single_ops[rand_bits(5) % 11], pick_operand(), pick_operand(),
                       pick_operand(), pick_operand());
      end
      mask = alu_pkg::lane_mask_t'(rand_bits(NL));
      prev = model_done;
      issue_lanes(mask);
      read_ok(`ALU_REG_DONE, rd, "DONE read");
      check_done(prev & ~mask, rd[NL-1:0]);
      read_ok(`ALU_REG_DONE, rd, "DONE read");
      check_done(prev | mask, rd[NL-1:0]);
      model_done = prev | mask;
      check_lane_results();
    end

    // Illegal control writes leave the old control in place.
    for (int k = 0; k < 4; k++) begin
      program_lane(k, single_ops[rand_bits(5) % 11], pick_operand(), pick_operand(),
                   pick_operand(), pick_operand());
      expect_write_err(lane_addr(k, `ALU_REG_CTRL), bad_ctrl[k], "illegal CTRL write");
      issue_lanes(alu_pkg::lane_mask_t'(1 << k));
      wait_done(alu_pkg::lane_mask_t'(1 << k));
      check_lane_results();
    end

    expect_write_err(12'h01C, 32'h1234_5678, "write to unused lane offset");
    expect_write_err(12'h080, 32'h1234_5678, "write above the lane windows");
    apb_read(12'h108, rd, err);
    check_err("read of unmapped address", 1'b1, err);
    expect_write_err(lane_addr(1, `ALU_REG_RES1), 32'hDEAD_BEEF, "write to RES1");
    expect_write_err(`ALU_REG_DONE, 32'h0, "write to DONE");
    apb_read(`ALU_REG_GO, rd, err);
    check_err("read of GO", 1'b1, err);
    check_lane_results();
    read_ok(`ALU_REG_DONE, rd, "DONE read");
    check_done(model_done, rd[NL-1:0]);

    $display("Errors: result %0d, done %0d, bus %0d", res_errs, done_errs, bus_errs);
    if (res_errs + done_errs + bus_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Four cycles per planned transfer, plus reset and slack.
  initial begin
    #(PLANNED_XFERS * 4 * CLK_PERIOD + 20 * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: build.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_apb_regs.sv
rtl/alu_lane.sv
rtl/alu_collect.sv
rtl/alu_array_top.sv
bench/alu_array_tb.sv

// File: rtl/alu_apb_regs.sv
`include "alu_defines.svh"

module alu_apb_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`ALU_ADDR_W-1:0]    paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic [31:0]               lane_res1 [`ALU_NUM_LANES],
  input  logic [31:0]               lane_res2 [`ALU_NUM_LANES],
  input  alu_pkg::lane_mask_t       done,
  output alu_pkg::alu_op_e          lane_op [`ALU_NUM_LANES],
  output logic [`ALU_NUM_LANES-1:0] lane_double_cal,
  output logic [31:0]               lane_src1 [`ALU_NUM_LANES],
  output logic [31:0]               lane_src2 [`ALU_NUM_LANES],
  output logic [31:0]               lane_src3 [`ALU_NUM_LANES],
  output logic [31:0]               lane_src4 [`ALU_NUM_LANES],
  output alu_pkg::lane_mask_t       issue
);

  localparam int OFS_W     = $clog2(`ALU_LANE_STRIDE);
  localparam int LANE_SPAN = `ALU_NUM_LANES * `ALU_LANE_STRIDE;

  logic                   access;
  logic                   wr_en;
  logic                   lane_hit;
  alu_pkg::lane_idx_t     lane_idx;
  logic [`ALU_ADDR_W-1:0] lane_ofs;
  logic                   hit_ctrl;
  logic                   hit_src1;
  logic                   hit_src2;
  logic                   hit_src3;
  logic                   hit_src4;
  logic                   hit_res1;
  logic                   hit_res2;
  logic                   hit_go;
  logic                   hit_done;
  logic                   mapped;
  logic                   ctrl_ok;
  logic                   wr_err;
  logic                   rd_err;

  assign access = psel & penable;

  // Lane windows sit at the bottom of the map.
  assign lane_hit = (paddr < `ALU_ADDR_W'(LANE_SPAN));
  assign lane_idx = paddr[OFS_W +: $bits(alu_pkg::lane_idx_t)];
  assign lane_ofs = `ALU_ADDR_W'(paddr[OFS_W-1:0]);

  assign hit_ctrl = lane_hit & (lane_ofs == `ALU_REG_CTRL);
  assign hit_src1 = lane_hit & (lane_ofs == `ALU_REG_SRC1);
  assign hit_src2 = lane_hit & (lane_ofs == `ALU_REG_SRC2);
  assign hit_src3 = lane_hit & (lane_ofs == `ALU_REG_SRC3);
  assign hit_src4 = lane_hit & (lane_ofs == `ALU_REG_SRC4);
  assign hit_res1 = lane_hit & (lane_ofs == `ALU_REG_RES1);
  assign hit_res2 = lane_hit & (lane_ofs == `ALU_REG_RES2);
  assign hit_go   = (paddr == `ALU_REG_GO);
  assign hit_done = (paddr == `ALU_REG_DONE);

  assign mapped = hit_ctrl | hit_src1 | hit_src2 | hit_src3 | hit_src4
                | hit_res1 | hit_res2 | hit_go | hit_done;

  // One op bit, and double_cal only with a branch.
  assign ctrl_ok = $onehot(pwdata[`ALU_CTRL_OP_MSB:0])
                && (pwdata[`ALU_CTRL_DCAL] == alu_pkg::is_branch(pwdata[`ALU_CTRL_OP_MSB:0]));

  assign wr_err = ~mapped | hit_res1 | hit_res2 | hit_done | (hit_ctrl & ~ctrl_ok);
  assign rd_err = ~mapped | hit_go;

  assign pready  = 1'b1;                               // No wait states.
  assign pslverr = access & (pwrite ? wr_err : rd_err);
  assign wr_en   = access & pwrite & ~wr_err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ALU_NUM_LANES; i++) begin
        lane_op[i]   <= alu_pkg::alu_op_e'(17'd0);    // No legal op yet.
        lane_src1[i] <= '0;
        lane_src2[i] <= '0;
        lane_src3[i] <= '0;
        lane_src4[i] <= '0;
      end
      lane_double_cal <= '0;
    end else if (wr_en && lane_hit) begin
      if (hit_ctrl) begin
        lane_op[lane_idx]         <= alu_pkg::alu_op_e'(pwdata[`ALU_CTRL_OP_MSB:0]);
        lane_double_cal[lane_idx] <= pwdata[`ALU_CTRL_DCAL];
      end
      if (hit_src1)
        lane_src1[lane_idx] <= pwdata;
      if (hit_src2)
        lane_src2[lane_idx] <= pwdata;
      if (hit_src3)
        lane_src3[lane_idx] <= pwdata;
      if (hit_src4)
        lane_src4[lane_idx] <= pwdata;
    end
  end

  // Single-cycle launch pulse.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      issue <= '0;
    else if (wr_en && hit_go)
      issue <= pwdata[`ALU_NUM_LANES-1:0];
    else
      issue <= '0;
  end

  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata[`ALU_CTRL_OP_MSB:0] = lane_op[lane_idx];
      prdata[`ALU_CTRL_DCAL]     = lane_double_cal[lane_idx];
    end else if (hit_src1) begin
      prdata = lane_src1[lane_idx];
    end else if (hit_src2) begin
      prdata = lane_src2[lane_idx];
    end else if (hit_src3) begin
      prdata = lane_src3[lane_idx];
    end else if (hit_src4) begin
      prdata = lane_src4[lane_idx];
    end else if (hit_res1) begin
      prdata = lane_res1[lane_idx];
    end else if (hit_res2) begin
      prdata = lane_res2[lane_idx];
    end else if (hit_done) begin
      prdata[`ALU_NUM_LANES-1:0] = done;
    end
  end

  // A launch always traces back to an accepted GO write.
  assert property (@(posedge clk) disable iff (!rst_n)
    |issue |-> $past(psel && penable && pwrite && hit_go))
    else $error("issue raised without a GO write");

endmodule

// File: rtl/alu_array_top.sv
`include "alu_defines.svh"

module alu_array_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ALU_ADDR_W-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);

  alu_pkg::alu_op_e          lane_op [`ALU_NUM_LANES];
  logic [`ALU_NUM_LANES-1:0] lane_double_cal;
  logic [31:0]               lane_src1 [`ALU_NUM_LANES];
  logic [31:0]               lane_src2 [`ALU_NUM_LANES];
  logic [31:0]               lane_src3 [`ALU_NUM_LANES];
  logic [31:0]               lane_src4 [`ALU_NUM_LANES];
  alu_pkg::lane_mask_t       issue;
  logic [31:0]               lane_result1 [`ALU_NUM_LANES];
  logic [31:0]               lane_result2 [`ALU_NUM_LANES];
  alu_pkg::lane_mask_t       lane_valid;
  logic [31:0]               res1 [`ALU_NUM_LANES];
  logic [31:0]               res2 [`ALU_NUM_LANES];
  alu_pkg::lane_mask_t       done;

  alu_apb_regs u_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .lane_res1       (res1),
    .lane_res2       (res2),
    .done            (done),
    .lane_op         (lane_op),
    .lane_double_cal (lane_double_cal),
    .lane_src1       (lane_src1),
    .lane_src2       (lane_src2),
    .lane_src3       (lane_src3),
    .lane_src4       (lane_src4),
    .issue           (issue)
  );

  for (genvar i = 0; i < `ALU_NUM_LANES; i++) begin : g_lane
    alu_lane u_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .op         (lane_op[i]),
      .double_cal (lane_double_cal[i]),
      .src1       (lane_src1[i]),
      .src2       (lane_src2[i]),
      .src3       (lane_src3[i]),
      .src4       (lane_src4[i]),
      .issue      (issue[i]),
      .result1    (lane_result1[i]),
      .result2    (lane_result2[i]),
      .valid      (lane_valid[i])
    );
  end

  alu_collect u_collect (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (lane_valid),
    .result1 (lane_result1),
    .result2 (lane_result2),
    .go      (issue),                                 // Launch clears done.
    .res1    (res1),
    .res2    (res2),
    .done    (done)
  );

endmodule

// File: rtl/alu_collect.sv
`include "alu_defines.svh"

module alu_collect (
  input  logic                clk,
  input  logic                rst_n,
  input  alu_pkg::lane_mask_t valid,
  input  logic [31:0]         result1 [`ALU_NUM_LANES],
  input  logic [31:0]         result2 [`ALU_NUM_LANES],
  input  alu_pkg::lane_mask_t go,
  output logic [31:0]         res1 [`ALU_NUM_LANES],
  output logic [31:0]         res2 [`ALU_NUM_LANES],
  output alu_pkg::lane_mask_t done
);

  alu_pkg::lane_mask_t done_d;

  // Result store, one slot per lane.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ALU_NUM_LANES; i++) begin
        res1[i] <= '0;
        res2[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `ALU_NUM_LANES; i++) begin
        if (valid[i]) begin
          res1[i] <= result1[i];                      // Re-issue overwrites.
          res2[i] <= result2[i];
        end
      end
    end
  end

  // A fresh launch wins over a result landing the same cycle.
  assign done_d = (done | valid) & ~go;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      done <= '0;
    else
      done <= done_d;
  end

  // Lane latency is fixed at two cycles after the launch pulse.
  for (genvar i = 0; i < `ALU_NUM_LANES; i++) begin : g_chk
    assert property (@(posedge clk) disable iff (!rst_n) valid[i] |-> $past(go[i], 2))
      else $error("lane %0d result without a launch", i);
  end

endmodule

// File: rtl/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

`define ALU_NUM_LANES   4
`define ALU_ADDR_W      12
`define ALU_LANE_STRIDE 32     // Bytes per lane window.

`define ALU_CTRL_OP_MSB 16     // Opcode field is [16:0].
`define ALU_CTRL_DCAL   31

// Offsets inside a lane window.
`define ALU_REG_CTRL 12'h000
`define ALU_REG_SRC1 12'h004
`define ALU_REG_SRC2 12'h008
`define ALU_REG_SRC3 12'h00C
`define ALU_REG_SRC4 12'h010
`define ALU_REG_RES1 12'h014   // Read only.
`define ALU_REG_RES2 12'h018   // Read only.

`define ALU_REG_GO   12'h100   // Write only.
`define ALU_REG_DONE 12'h104   // Read only.

`endif

// File: rtl/alu_lane.sv
module alu_lane (
  input  logic             clk,
  input  logic             rst_n,
  input  alu_pkg::alu_op_e op,
  input  logic             double_cal,
  input  logic [31:0]      src1,
  input  logic [31:0]      src2,
  input  logic [31:0]      src3,
  input  logic [31:0]      src4,
  input  logic             issue,
  output logic [31:0]      result1,
  output logic [31:0]      result2,
  output logic             valid
);

  alu_pkg::alu_op_e op_q;
  logic             dcal_q;
  logic [31:0]      a_q;
  logic [31:0]      b_q;
  logic [31:0]      c_q;
  logic [31:0]      d_q;
  logic             busy_q;

  logic        op_add;
  logic        op_sub;
  logic        op_slt;
  logic        op_sltu;
  logic        op_and;
  logic        op_or;
  logic        op_xor;
  logic        op_sll;
  logic        op_srl;
  logic        op_sra;
  logic        op_lui;
  logic        op_bne;
  logic        op_beq;
  logic        op_bge;
  logic        op_bgeu;
  logic        op_blt;
  logic        op_bltu;
  logic        sub_mode;
  logic [31:0] add_b;
  logic [31:0] add_sum;
  logic        add_cout;
  logic [31:0] cmp_diff;
  logic        cmp_cout;
  logic        slt_bit;
  logic        blt_bit;
  logic        bltu_bit;
  logic        beq_bit;
  logic        br_taken;
  logic [63:0] sr64;
  logic [31:0] res1_d;
  logic [31:0] res2_d;

  // Operands are frozen on issue.
  always_ff @(posedge clk) begin
    if (issue) begin
      op_q   <= op;
      dcal_q <= double_cal;
      a_q    <= src1;
      b_q    <= src2;
      c_q    <= src3;
      d_q    <= src4;
    end
  end

  assign op_add  = |(op_q & alu_pkg::OP_ADD);
  assign op_sub  = |(op_q & alu_pkg::OP_SUB);
  assign op_slt  = |(op_q & alu_pkg::OP_SLT);
  assign op_sltu = |(op_q & alu_pkg::OP_SLTU);
  assign op_and  = |(op_q & alu_pkg::OP_AND);
  assign op_or   = |(op_q & alu_pkg::OP_OR);
  assign op_xor  = |(op_q & alu_pkg::OP_XOR);
  assign op_sll  = |(op_q & alu_pkg::OP_SLL);
  assign op_srl  = |(op_q & alu_pkg::OP_SRL);
  assign op_sra  = |(op_q & alu_pkg::OP_SRA);
  assign op_lui  = |(op_q & alu_pkg::OP_LUI);
  assign op_bne  = |(op_q & alu_pkg::OP_BNE);
  assign op_beq  = |(op_q & alu_pkg::OP_BEQ);
  assign op_bge  = |(op_q & alu_pkg::OP_BGE);
  assign op_bgeu = |(op_q & alu_pkg::OP_BGEU);
  assign op_blt  = |(op_q & alu_pkg::OP_BLT);
  assign op_bltu = |(op_q & alu_pkg::OP_BLTU);

  // Main adder, also the branch target.
  assign sub_mode = op_sub | op_slt | op_sltu;
  assign add_b    = sub_mode ? ~b_q : b_q;
  assign {add_cout, add_sum} = {1'b0, a_q} + {1'b0, add_b} + {32'd0, sub_mode};

  // Compare adder, always src3 - src4.
  assign {cmp_cout, cmp_diff} = {1'b0, c_q} + {1'b0, ~d_q} + 33'd1;

  assign slt_bit  = (a_q[31] & ~b_q[31]) | ((a_q[31] ~^ b_q[31]) & add_sum[31]);
  assign blt_bit  = (c_q[31] & ~d_q[31]) | ((c_q[31] ~^ d_q[31]) & cmp_diff[31]);
  assign bltu_bit = ~cmp_cout;
  assign beq_bit  = (c_q == d_q);

  assign br_taken = (op_beq  &  beq_bit)  | (op_bne  & ~beq_bit)
                  | (op_blt  &  blt_bit)  | (op_bge  & ~blt_bit)
                  | (op_bltu &  bltu_bit) | (op_bgeu & ~bltu_bit);

  assign sr64 = {{32{op_sra & a_q[31]}}, a_q} >> b_q[4:0];

  assign res1_d = ({32{op_add | op_sub | dcal_q}} & add_sum)
                | ({32{op_slt}}          & {31'b0, slt_bit})
                | ({32{op_sltu}}         & {31'b0, ~add_cout})
                | ({32{op_and}}          & (a_q & b_q))
                | ({32{op_or}}           & (a_q | b_q))
                | ({32{op_xor}}          & (a_q ^ b_q))
                | ({32{op_lui}}          & b_q)
                | ({32{op_sll}}          & (a_q << b_q[4:0]))
                | ({32{op_srl | op_sra}} & sr64[31:0]);

  assign res2_d = dcal_q ? {31'b0, br_taken} : 32'd1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      valid   <= 1'b0;
      result1 <= '0;
      result2 <= '0;
    end else begin
      busy_q <= issue;
      valid  <= busy_q;
      if (busy_q) begin
        result1 <= res1_d;
        result2 <= res2_d;
      end
    end
  end

  // Register block only lets legal controls through.
  assert property (@(posedge clk) disable iff (!rst_n) issue |-> $onehot(op))
    else $error("lane issued with a non one-hot op");

endmodule

// File: rtl/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

  // One-hot, in the bit order of the ALU control field.
  typedef enum logic [16:0] {
    OP_ADD  = 17'h00001,
    OP_SUB  = 17'h00002,
    OP_SLT  = 17'h00004,
    OP_SLTU = 17'h00008,
    OP_AND  = 17'h00010,
    OP_OR   = 17'h00020,
    OP_XOR  = 17'h00040,
    OP_SLL  = 17'h00080,
    OP_SRL  = 17'h00100,
    OP_SRA  = 17'h00200,
    OP_LUI  = 17'h00400,
    OP_BNE  = 17'h00800,
    OP_BEQ  = 17'h01000,
    OP_BGE  = 17'h02000,
    OP_BGEU = 17'h04000,
    OP_BLT  = 17'h08000,
    OP_BLTU = 17'h10000
  } alu_op_e;

  typedef logic [`ALU_NUM_LANES-1:0]         lane_mask_t;
  typedef logic [$clog2(`ALU_NUM_LANES)-1:0] lane_idx_t;

  // True for any of the six branch compares.
  function automatic logic is_branch(input logic [16:0] op);
    logic [16:0] br_mask;
    br_mask = OP_BNE | OP_BEQ | OP_BGE | OP_BGEU | OP_BLT | OP_BLTU;
    return |(op & br_mask);
  endfunction

endpackage
